// ==== src/led_matrix_settings.svh ====
// panel geometry and display timing macros, included by every led matrix file that sizes logic
`ifndef LED_MATRIX_SETTINGS_SVH
`define LED_MATRIX_SETTINGS_SVH

`default_nettype none

// panel geometry
// columns per panel row, one pixel clock each
`define LED_PANEL_COLS 64
// rows per half, top and bottom halves scan together
`define LED_SCAN_ROWS 16

// binary coded modulation
// bit planes per colour channel
`define LED_PLANES 6
// oe_n low cycles for plane 0, plane p gets this times 2**p
`define LED_DISPLAY_UNIT 8

// scan timing
// idle cycles after the last pixel request so the pipeline empties before latch
`define LED_PIPE_DRAIN 4

// frame buffer
// two halves of 16 rows by 64 columns
`define LED_FB_DEPTH 2048

`default_nettype wire

`endif

// ==== src/led_matrix_pkg.sv ====
// shared pixel, request and state types for the led matrix pipeline, referenced by scoped names
`default_nettype none

package led_matrix_pkg;

	// one pixel as the host writes it
	// red in the top bits, blue in the bottom bits
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// host write into the frame buffer
	// addr is {half, row, col}
	typedef struct packed {
		logic [10:0] addr;
		rgb565_t     pixel;
	} fb_wr_t;

	// one column request from the scan stage
	// row is shared by both halves
	typedef struct packed {
		logic [3:0] row;
		logic [5:0] col;
		logic [2:0] plane;
	} scan_req_t;

	// top and bottom pixel of one column
	// plane travels with the data so split needs no scan state
	typedef struct packed {
		rgb565_t    top;
		rgb565_t    bottom;
		logic [2:0] plane;
	} pixel_pair_t;

	// scan sequencer states, in the order they run per row and plane
	typedef enum logic [1:0] {
		scan_shift,
		scan_drain,
		scan_latch,
		scan_display
	} scan_state_e;

endpackage

`default_nettype wire

// ==== src/frame_buffer.sv ====
// rgb565 frame memory for the panel, host writes on one port and the fetch stage reads two pixels
`include "led_matrix_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module frame_buffer (
	input  wire logic                    clk_root,
	input  wire logic                    rst_n,
	// host write port
	input  wire logic                    wr_en,
	input  wire led_matrix_pkg::fb_wr_t  wr,
	// read addresses from fetch, top half and bottom half
	input  wire logic [10:0]             rd_addr_top,
	input  wire logic [10:0]             rd_addr_bottom,
	// registered read data, one cycle after the address
	output led_matrix_pkg::rgb565_t      rd_data_top,
	output led_matrix_pkg::rgb565_t      rd_data_bottom
);

	// whole frame, both halves
	// address msb picks the half
	led_matrix_pkg::rgb565_t mem [`LED_FB_DEPTH];

	// write port
	// new value visible to reads one cycle later
	always_ff @(posedge clk_root) begin
		if (wr_en) begin
			mem[wr.addr] <= wr.pixel;
		end
	end

	// read ports, registered like block ram outputs
	// same-cycle read of a written address returns the old pixel
	always_ff @(posedge clk_root) begin
		rd_data_top    <= mem[rd_addr_top];
		rd_data_bottom <= mem[rd_addr_bottom];
	end

	// host must never write to an unknown address
	// an X address would corrupt the whole memory in simulation
	wr_addr_known: assert property (
		@(posedge clk_root) disable iff (!rst_n)
		wr_en |-> !$isunknown(wr.addr)
	) else $error("frame_buffer: write with unknown address");

endmodule

`default_nettype wire

// ==== src/matrix_scan.sv ====
// row and bit plane sequencer, issues column requests and drives latch, row address and oe_n
`include "led_matrix_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module matrix_scan (
	input  wire logic                clk_root,
	input  wire logic                rst_n,
	// column request to fetch, one every other shift cycle
	output logic                     req_valid,
	output led_matrix_pkg::scan_req_t req,
	// panel control pins
	output logic                     row_latch,
	output logic [3:0]               row_addr,
	output logic                     oe_n
);

	// counter widths
	// display counter must hold the weight of the top plane
	localparam int drain_width = $clog2(`LED_PIPE_DRAIN + 1);
	localparam int disp_width  = $clog2((`LED_DISPLAY_UNIT << (`LED_PLANES - 1)) + 1);

	// terminal counts
	localparam logic [5:0] last_col   = 6'(`LED_PANEL_COLS - 1);
	localparam logic [2:0] last_plane = 3'(`LED_PLANES - 1);
	localparam logic [3:0] last_row   = 4'(`LED_SCAN_ROWS - 1);

	led_matrix_pkg::scan_state_e state;

	// phase 0 issues a request, phase 1 is the gap
	logic                   phase;
	logic [5:0]             col;
	logic [2:0]             plane;
	logic [3:0]             row;
	logic [drain_width-1:0] drain_cnt;
	logic [disp_width-1:0]  disp_cnt;

	// request decode straight from the state register
	assign req_valid = (state == led_matrix_pkg::scan_shift) && !phase;
	assign req       = '{row: row, col: col, plane: plane};

	// panel control decode
	// latch is a single cycle state, display is the only lit state
	assign row_latch = (state == led_matrix_pkg::scan_latch);
	assign oe_n      = (state != led_matrix_pkg::scan_display);

	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			state     <= led_matrix_pkg::scan_shift;
			phase     <= 1'b0;
			col       <= '0;
			plane     <= '0;
			row       <= '0;
			drain_cnt <= '0;
			disp_cnt  <= '0;
			row_addr  <= '0;
		end else begin
			case (state)
				led_matrix_pkg::scan_shift: begin
					// gap cycle, next cycle requests again
					if (phase) begin
						phase <= 1'b0;
					end else if (col == last_col) begin
						// last request of the row goes out this cycle
						col       <= '0;
						drain_cnt <= '0;
						state     <= led_matrix_pkg::scan_drain;
					end else begin
						col   <= col + 1'b1;
						phase <= 1'b1;
					end
				end
				led_matrix_pkg::scan_drain: begin
					// wait out fetch, split and pixel clock stages
					if (drain_cnt == drain_width'(`LED_PIPE_DRAIN - 1)) begin
						// panel sees the new row together with the latch
						row_addr <= row;
						state    <= led_matrix_pkg::scan_latch;
					end else begin
						drain_cnt <= drain_cnt + 1'b1;
					end
				end
				led_matrix_pkg::scan_latch: begin
					// plane weight sets the lit time, binary coded modulation
					disp_cnt <= disp_width'(`LED_DISPLAY_UNIT) << plane;
					state    <= led_matrix_pkg::scan_display;
				end
				led_matrix_pkg::scan_display: begin
					if (disp_cnt == disp_width'(1)) begin
						phase <= 1'b0;
						state <= led_matrix_pkg::scan_shift;
						// planes first, then rows
						if (plane == last_plane) begin
							plane <= '0;
							row   <= (row == last_row) ? 4'd0 : row + 1'b1;
						end else begin
							plane <= plane + 1'b1;
						end
					end else begin
						disp_cnt <= disp_cnt - 1'b1;
					end
				end
				default: begin
					state <= led_matrix_pkg::scan_shift;
				end
			endcase
		end
	end

	// panel lights only in the cycle after a latch
	latch_dark: assert property (
		@(posedge clk_root) disable iff (!rst_n)
		$fell(oe_n) |-> $past(row_latch)
	) else $error("matrix_scan: panel lit without a row_latch before it");

	// requests never back to back
	req_in_shift: assert property (
		@(posedge clk_root) disable iff (!rst_n)
		req_valid |=> !req_valid
	) else $error("matrix_scan: back to back requests");

endmodule

`default_nettype wire

// ==== src/framebuffer_fetch.sv ====
// fetch stage, turns a column request into two buffer reads and returns the top and bottom pixels
`default_nettype none
`timescale 1ns/10ps

module framebuffer_fetch (
	input  wire logic                      clk_root,
	input  wire logic                      rst_n,
	// request from the scan stage
	input  wire logic                      req_valid,
	input  wire led_matrix_pkg::scan_req_t req,
	// frame buffer read side
	output logic [10:0]                    rd_addr_top,
	output logic [10:0]                    rd_addr_bottom,
	input  wire led_matrix_pkg::rgb565_t   rd_data_top,
	input  wire led_matrix_pkg::rgb565_t   rd_data_bottom,
	// fetched pair to the split stage
	output logic                           pair_valid,
	output led_matrix_pkg::pixel_pair_t    pair
);

	// plane of the request in flight
	// rides alongside the ram read latency
	logic [2:0] plane_q;

	// address is {half, row, col}
	// both halves read the same row and column
	assign rd_addr_top    = {1'b0, req.row, req.col};
	assign rd_addr_bottom = {1'b1, req.row, req.col};

	// valid strobe delay, matches one cycle ram latency
	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			pair_valid <= 1'b0;
		end else begin
			pair_valid <= req_valid;
		end
	end

	// plane follows the data
	// only meaningful when pair_valid is high
	always_ff @(posedge clk_root) begin
		if (req_valid) begin
			plane_q <= req.plane;
		end
	end

	// bundle ram outputs with the delayed plane
	assign pair = '{
		top:    rd_data_top,
		bottom: rd_data_bottom,
		plane:  plane_q
	};

	// every request comes back exactly one cycle later with its own plane
	pair_follows_req: assert property (
		@(posedge clk_root) disable iff (!rst_n)
		req_valid |=> pair_valid && pair.plane == $past(req.plane)
	) else $error("framebuffer_fetch: pair missing or plane misaligned");

endmodule

`default_nettype wire

// ==== src/pixel_split.sv ====
// split stage, picks the current plane bit of each channel, masks it and drives panel data
`include "led_matrix_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module pixel_split (
	input  wire logic                        clk_root,
	input  wire logic                        rst_n,
	// fetched pair from the fetch stage
	input  wire logic                        pair_valid,
	input  wire led_matrix_pkg::pixel_pair_t pair,
	// global enables, bit 0 red, bit 1 green, bit 2 blue
	input  wire logic [2:0]                  rgb_enable,
	input  wire logic [`LED_PLANES-1:0]      brightness_enable,
	// panel data pins and shift clock
	output logic [2:0]                       rgb_top,
	output logic [2:0]                       rgb_bottom,
	output logic                             clk_pixel
);

	// data registered one cycle before the pixel clock edge
	logic load_q;
	logic [2:0] bits_top;
	logic [2:0] bits_bottom;

	// red and blue widened to 6 bits by repeating their msb
	// green is already 6 bits
	function automatic logic [2:0] plane_bits(
		input led_matrix_pkg::rgb565_t px,
		input logic [2:0]              plane
	);
		logic [5:0] red6;
		logic [5:0] blue6;
		red6  = {px.red, px.red[4]};
		blue6 = {px.blue, px.blue[4]};
		return {blue6[plane], px.green[plane], red6[plane]};
	endfunction

	// channel enable per bit, plane enable for all three
	assign bits_top    = plane_bits(pair.top, pair.plane) & rgb_enable
		& {3{brightness_enable[pair.plane]}};
	assign bits_bottom = plane_bits(pair.bottom, pair.plane) & rgb_enable
		& {3{brightness_enable[pair.plane]}};

	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			rgb_top    <= '0;
			rgb_bottom <= '0;
			load_q     <= 1'b0;
			clk_pixel  <= 1'b0;
		end else begin
			if (pair_valid) begin
				rgb_top    <= bits_top;
				rgb_bottom <= bits_bottom;
			end
			// clock rises a full cycle after the data settles
			load_q    <= pair_valid;
			clk_pixel <= load_q;
		end
	end

endmodule

`default_nettype wire

// ==== src/led_matrix_top.sv ====
// led matrix driver top, wires scan, fetch, frame buffer and split stages to the panel pins
`include "led_matrix_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module led_matrix_top (
	input  wire logic                   clk_root,
	input  wire logic                   rst_n,
	// host pixel writes
	input  wire logic                   wr_en,
	input  wire led_matrix_pkg::fb_wr_t wr,
	// global enables, sampled every cycle
	input  wire logic [2:0]             rgb_enable,
	input  wire logic [`LED_PLANES-1:0] brightness_enable,
	// hub75 panel pins
	output logic [2:0]                  rgb_top,
	output logic [2:0]                  rgb_bottom,
	output logic                        clk_pixel,
	output logic                        row_latch,
	output logic [3:0]                  row_addr,
	output logic                        oe_n
);

	// scan to fetch
	logic                        req_valid;
	led_matrix_pkg::scan_req_t   req;

	// fetch to frame buffer and back
	logic [10:0]                 rd_addr_top;
	logic [10:0]                 rd_addr_bottom;
	led_matrix_pkg::rgb565_t     rd_data_top;
	led_matrix_pkg::rgb565_t     rd_data_bottom;

	// fetch to split
	logic                        pair_valid;
	led_matrix_pkg::pixel_pair_t pair;

	// row and plane sequencer, owns latch, row address and oe_n
	matrix_scan u_scan (
		.clk_root  (clk_root),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.row_latch (row_latch),
		.row_addr  (row_addr),
		.oe_n      (oe_n)
	);

	// address forming and read alignment
	framebuffer_fetch u_fetch (
		.clk_root       (clk_root),
		.rst_n          (rst_n),
		.req_valid      (req_valid),
		.req            (req),
		.rd_addr_top    (rd_addr_top),
		.rd_addr_bottom (rd_addr_bottom),
		.rd_data_top    (rd_data_top),
		.rd_data_bottom (rd_data_bottom),
		.pair_valid     (pair_valid),
		.pair           (pair)
	);

	// frame memory, host write port plus two read ports
	frame_buffer u_fb (
		.clk_root       (clk_root),
		.rst_n          (rst_n),
		.wr_en          (wr_en),
		.wr             (wr),
		.rd_addr_top    (rd_addr_top),
		.rd_addr_bottom (rd_addr_bottom),
		.rd_data_top    (rd_data_top),
		.rd_data_bottom (rd_data_bottom)
	);

	// plane bit select, masking and pixel clock
	pixel_split u_split (
		.clk_root          (clk_root),
		.rst_n             (rst_n),
		.pair_valid        (pair_valid),
		.pair              (pair),
		.rgb_enable        (rgb_enable),
		.brightness_enable (brightness_enable),
		.rgb_top           (rgb_top),
		.rgb_bottom        (rgb_bottom),
		.clk_pixel         (clk_pixel)
	);

endmodule

`default_nettype wire

// ==== test/led_matrix_tb.sv ====
// testbench for the led matrix driver, loads a random frame and checks the panel pins against a model
`include "led_matrix_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module led_matrix_tb;

	// one frame is 16 rows of 6 planes, each shift + drain + latch + display
	localparam int frame_cycles = `LED_SCAN_ROWS * (`LED_PLANES
		* (2 * `LED_PANEL_COLS - 1 + `LED_PIPE_DRAIN + 1)
		+ `LED_DISPLAY_UNIT * ((1 << `LED_PLANES) - 1));
	// three frames plus load, with margin
	localparam int timeout_cycles = 100000;
	// frames 2 and 3 are checked
	localparam int expected_pixels = 2 * `LED_SCAN_ROWS * `LED_PLANES * `LED_PANEL_COLS;

	logic                        clk_root = 1'b0;
	logic                        rst_n;
	logic                        wr_en;
	led_matrix_pkg::fb_wr_t      wr;
	logic [2:0]                  rgb_enable;
	logic [`LED_PLANES-1:0]      brightness_enable;
	logic [2:0]                  rgb_top;
	logic [2:0]                  rgb_bottom;
	logic                        clk_pixel;
	logic                        row_latch;
	logic [3:0]                  row_addr;
	logic                        oe_n;

	// random source and reference frame
	logic [31:0] lfsr = 32'hbd6a;
	logic [15:0] model_frame [`LED_FB_DEPTH];

	// model scan position
	logic [3:0] m_row = '0;
	logic [2:0] m_plane = '0;
	int         pix_cnt = 0;
	int         low_cnt = 0;
	logic       latched = 1'b0;
	int         frame_cnt = 0;
	logic       checking = 1'b0;
	logic       run_done = 1'b0;
	int         pix_checked = 0;

	// run limit
	int   cycle_cnt = 0;
	logic timed_out = 1'b0;

	// error counts by kind
	int data_err = 0;
	int timing_err = 0;
	int row_err = 0;
	int reset_err = 0;

	always #4 clk_root = ~clk_root;

	led_matrix_top u_led_matrix_top (
		.clk_root          (clk_root),
		.rst_n             (rst_n),
		.wr_en             (wr_en),
		.wr                (wr),
		.rgb_enable        (rgb_enable),
		.brightness_enable (brightness_enable),
		.rgb_top           (rgb_top),
		.rgb_bottom        (rgb_bottom),
		.clk_pixel         (clk_pixel),
		.row_latch         (row_latch),
		.row_addr          (row_addr),
		.oe_n              (oe_n)
	);

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [15:0] draw_bits(input int n);
		logic [15:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[14:0], fb};
		end
		return v;
	endfunction

	// expected pin bits {blue, green, red} for one rgb565 pixel
	function automatic logic [2:0] expect_bits(input logic [15:0] px, input logic [2:0] plane,
		input logic [2:0] ren, input logic [5:0] ben);
		logic [5:0] r6;
		logic [5:0] g6;
		logic [5:0] b6;
		r6 = {px[15:11], px[15]};
		g6 = px[10:5];
		b6 = {px[4:0], px[4]};
		if (!ben[plane]) begin
			return 3'b000;
		end
		return {b6[plane] & ren[2], g6[plane] & ren[1], r6[plane] & ren[0]};
	endfunction

	always @(posedge clk_root) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			timed_out <= 1'b1;
		end
	end

	// pin monitor, sees the values of the cycle just ended
	always @(posedge clk_root) begin : monitor
		logic [2:0] exp_top;
		logic [2:0] exp_bottom;
		int         exp_low;
		if (rst_n && !run_done) begin
			if (clk_pixel) begin
				if (checking) begin
					exp_top = expect_bits(model_frame[{1'b0, m_row, 6'(pix_cnt)}], m_plane,
						rgb_enable, brightness_enable);
					exp_bottom = expect_bits(model_frame[{1'b1, m_row, 6'(pix_cnt)}], m_plane,
						rgb_enable, brightness_enable);
					assert (rgb_top == exp_top) else begin
						$display("FAIL %0t rgb_top expected %b actual %b", $time, exp_top, rgb_top);
						data_err++;
					end
					assert (rgb_bottom == exp_bottom) else begin
						$display("FAIL %0t rgb_bottom expected %b actual %b", $time, exp_bottom,
							rgb_bottom);
						data_err++;
					end
					assert (oe_n == 1'b1) else begin
						$display("FAIL %0t oe_n expected 1 actual %b at clk_pixel", $time, oe_n);
						timing_err++;
					end
					pix_checked++;
				end
				pix_cnt++;
			end
			if (row_latch) begin
				if (checking) begin
					assert (pix_cnt == `LED_PANEL_COLS) else begin
						$display("FAIL %0t clk_pixel count expected %0d actual %0d", $time,
							`LED_PANEL_COLS, pix_cnt);
						timing_err++;
					end
					assert (oe_n == 1'b1) else begin
						$display("FAIL %0t oe_n expected 1 actual %b at row_latch", $time, oe_n);
						timing_err++;
					end
					assert (row_addr == m_row) else begin
						$display("FAIL %0t row_addr expected %0d actual %0d", $time, m_row, row_addr);
						row_err++;
					end
				end
				pix_cnt = 0;
				low_cnt = 0;
				latched = 1'b1;
				// enables for the next shift
				// the host load draws from the lfsr until the frame is written
				if (!wr_en) begin
					rgb_enable        <= 3'(draw_bits(3));
					brightness_enable <= 6'(draw_bits(6));
				end
			end else if (!oe_n) begin
				if (checking) begin
					assert (latched) else begin
						$display("oe_n went low at %0t without a row_latch before it", $time);
						timing_err++;
					end
					assert (row_addr == m_row) else begin
						$display("FAIL %0t row_addr expected %0d actual %0d", $time, m_row, row_addr);
						row_err++;
					end
				end
				low_cnt++;
			end else if (latched) begin
				// display just ended, plane weight sets its length
				exp_low = `LED_DISPLAY_UNIT << m_plane;
				if (checking) begin
					assert (low_cnt == exp_low) else begin
						$display("FAIL %0t oe_n low cycles expected %0d actual %0d", $time,
							exp_low, low_cnt);
						timing_err++;
					end
				end
				latched = 1'b0;
				// planes first, then rows
				if (m_plane == 3'(`LED_PLANES - 1)) begin
					m_plane = '0;
					if (m_row == 4'(`LED_SCAN_ROWS - 1)) begin
						m_row = '0;
						frame_cnt++;
					end else begin
						m_row = m_row + 1'b1;
					end
				end else begin
					m_plane = m_plane + 1'b1;
				end
				checking = (frame_cnt >= 1) && (frame_cnt < 3);
				run_done = (frame_cnt >= 3);
			end
		end
	end

	initial begin
		logic [15:0] px;
		rst_n             = 1'b0;
		wr_en             = 1'b0;
		wr                = '0;
		rgb_enable        = 3'b111;
		brightness_enable = '1;
		repeat (5) @(posedge clk_root);
		rst_n <= 1'b1;
		@(posedge clk_root);
		// first cycle out of reset, panel dark and idle
		assert (clk_pixel == 1'b0 && row_latch == 1'b0) else begin
			$display("FAIL %0t clk_pixel/row_latch expected 0/0 actual %b/%b", $time,
				clk_pixel, row_latch);
			reset_err++;
		end
		assert (rgb_top == 3'b000 && rgb_bottom == 3'b000) else begin
			$display("FAIL %0t rgb_top/rgb_bottom expected 000/000 actual %b/%b", $time,
				rgb_top, rgb_bottom);
			reset_err++;
		end
		assert (oe_n == 1'b1 && row_addr == 4'd0) else begin
			$display("FAIL %0t oe_n/row_addr expected 1/0 actual %b/%0d", $time, oe_n, row_addr);
			reset_err++;
		end
		// whole frame once, random colours
		for (int i = 0; i < `LED_FB_DEPTH; i++) begin
			px = draw_bits(16);
			model_frame[i] = px;
			wr_en    <= 1'b1;
			wr.addr  <= 11'(i);
			wr.pixel <= px;
			@(posedge clk_root);
		end
		wr_en <= 1'b0;
		wait (run_done || timed_out);
		if (timed_out) begin
			$display("run stopped after %0d cycles, frame %0d of 3 (one frame is %0d cycles)",
				cycle_cnt, frame_cnt, frame_cycles);
		end else begin
			assert (pix_checked == expected_pixels) else begin
				$display("only %0d of %0d pixels were checked", pix_checked, expected_pixels);
				timing_err++;
			end
		end
		$display("errors: data %0d timing %0d row %0d reset %0d, pixels checked %0d",
			data_err, timing_err, row_err, reset_err, pix_checked);
		if (!timed_out && data_err + timing_err + row_err + reset_err == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/led_matrix_pkg.sv
src/frame_buffer.sv
src/matrix_scan.sv
src/framebuffer_fetch.sv
src/pixel_split.sv
src/led_matrix_top.sv
test/led_matrix_tb.sv
